/* verilog.f */
source/csr_pkg.sv
source/csr_access_decode.sv
source/core_csrs.sv
source/nc_region_csr.sv
source/csr_read_mux.sv
source/csr_file_top.sv
tests/csr_file_asserts.sv
tests/csr_file_tb.sv

/* run.sh */
#!/bin/sh
# build the csr file testbench with verilator, run it, then scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module csr_file_tb -o csr_file_sim -f verilog.f \
    && ./obj_dir/csr_file_sim 2>&1 | tee sim.log \
    || echo "build or run failed" | tee -a sim.log

# a run that never reached its closing line fails as well
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

/* tests/csr_file_tb.sv */
`default_nettype none

module csr_file_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int N_REGIONS = 2;

    logic      clk;
    logic      rst_n;
    csr_addr_t address;
    csr_f3_t   f3;
    csr_data_t write_data;
    logic      write_enable;
    logic      instruction_valid;
    csr_data_t current_pc;
    logic      exception;
    cause_t    exception_cause;
    logic      m_ret;
    logic      timer_itr;
    logic      soft_itr;
    logic      ext_itr;
    csr_data_t read_data;
    logic      trap;
    csr_data_t csr_mtvec;
    csr_data_t csr_mepc;
    logic      flush_cache_flag;
    csr_data_t nc_base  [N_REGIONS];
    csr_data_t nc_limit [N_REGIONS];

    // wrong values, and everything else
    int mismatches;
    int failures;

    csr_file_top #(
        .N_REGIONS(N_REGIONS)
    ) dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .address          (address),
        .f3               (f3),
        .write_data       (write_data),
        .write_enable     (write_enable),
        .instruction_valid(instruction_valid),
        .current_pc       (current_pc),
        .exception        (exception),
        .exception_cause  (exception_cause),
        .m_ret            (m_ret),
        .timer_itr        (timer_itr),
        .soft_itr         (soft_itr),
        .ext_itr          (ext_itr),
        .read_data        (read_data),
        .trap             (trap),
        .csr_mtvec        (csr_mtvec),
        .csr_mepc         (csr_mepc),
        .flush_cache_flag (flush_cache_flag),
        .nc_base          (nc_base),
        .nc_limit         (nc_limit)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    task automatic check(input string name, input csr_data_t got, input csr_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // next drive point, 10 ns past the edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic bus_idle();
        address           = '0;
        f3                = '0;
        write_data        = '0;
        write_enable      = 1'b0;
        instruction_valid = 1'b0;
    endtask

    // one csr instruction, commits on the next edge when valid
    task automatic csr_access(input csr_addr_t addr, input csr_f3_t op,
                              input csr_data_t data, input logic valid);
        address           = addr;
        f3                = op;
        write_data        = data;
        write_enable      = 1'b1;
        instruction_valid = valid;
        step();
        bus_idle();
    endtask

    // combinational read, sampled 1 ns after drive
    task automatic expect_csr(input string name, input csr_addr_t addr, input csr_data_t exp);
        address           = addr;
        f3                = 3'd2;
        write_data        = '0;
        write_enable      = 1'b0;
        instruction_valid = 1'b1;
        #1;
        check(name, read_data, exp);
        step();
        bus_idle();
    endtask

    // bounded wait for trap, returns past the commit edge
    task automatic wait_for_trap(input int max_cycles, output int cycles);
        cycles = 0;
        #1;
        while (trap !== 1'b1 && cycles < max_cycles) begin
            step();
            #1;
            cycles++;
        end
        if (trap !== 1'b1) begin
            $display("timeout: trap not raised within %0d cycles", max_cycles);
            failures++;
        end
        step();
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic reset_values_test();
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1800);
        expect_csr("misa", ADDR_MISA, 32'h4014_0100);
        for (int i = 0; i < N_REGIONS; i++) begin
            expect_csr($sformatf("nc base csr %0d", i),
                       csr_addr_t'(ADDR_NC_FIRST + 2 * i), 32'h0);
            expect_csr($sformatf("nc limit csr %0d", i),
                       csr_addr_t'(ADDR_NC_FIRST + 2 * i + 1), 32'hFFFF_FFFF);
            check($sformatf("nc_base[%0d]", i), nc_base[i], 32'h0);
            check($sformatf("nc_limit[%0d]", i), nc_limit[i], 32'hFFFF_FFFF);
        end
        check("trap", {31'd0, trap}, 32'd0);
        check("flush_cache_flag", {31'd0, flush_cache_flag}, 32'd0);
    endtask

    task automatic write_forms_test();
        csr_addr_t addr;
        csr_f3_t   base_op;
        csr_data_t model;
        csr_data_t value;
        string     name;
        for (int k = 0; k < 2; k++) begin
            // mscratch via register forms, mtvec via immediate forms
            addr    = (k == 0) ? ADDR_MSCRATCH : ADDR_MTVEC;
            base_op = (k == 0) ? 3'd0 : 3'd4;
            name    = (k == 0) ? "mscratch" : "mtvec";
            value = $urandom;
            model = value;
            csr_access(addr, base_op | 3'd1, value, 1'b1);
            expect_csr(name, addr, model);
            // set bits
            value = $urandom;
            model = model | value;
            csr_access(addr, base_op | 3'd2, value, 1'b1);
            expect_csr(name, addr, model);
            // clear bits
            value = $urandom;
            model = model & ~value;
            csr_access(addr, base_op | 3'd3, value, 1'b1);
            expect_csr(name, addr, model);
            if (k == 1) begin
                check("csr_mtvec", csr_mtvec, model);
            end
        end
        // f3 of 4 is no write form, result is 0
        csr_access(ADDR_MSCRATCH, 3'd4, 32'hFFFF_FFFF, 1'b1);
        expect_csr("mscratch", ADDR_MSCRATCH, 32'h0);
        expect_csr("unmapped 0x123", 12'h123, 32'h0);
        expect_csr("unmapped 0x7c5", 12'h7C5, 32'h0);
        // invalid instruction must not commit
        value = $urandom;
        csr_access(ADDR_MSCRATCH, 3'd1, 32'hA5A5_5A5A, 1'b1);
        csr_access(ADDR_MSCRATCH, 3'd1, value, 1'b0);
        expect_csr("mscratch", ADDR_MSCRATCH, 32'hA5A5_5A5A);
    endtask

    task automatic windows_test();
        csr_data_t base_val  [N_REGIONS];
        csr_data_t limit_val [N_REGIONS];
        for (int i = 0; i < N_REGIONS; i++) begin
            base_val[i]  = $urandom;
            limit_val[i] = $urandom;
            csr_access(csr_addr_t'(ADDR_NC_FIRST + 2 * i), 3'd1, base_val[i], 1'b1);
            csr_access(csr_addr_t'(ADDR_NC_FIRST + 2 * i + 1), 3'd1, limit_val[i], 1'b1);
        end
        // all written first, so a stray strobe shows up here
        for (int i = 0; i < N_REGIONS; i++) begin
            expect_csr($sformatf("nc base csr %0d", i),
                       csr_addr_t'(ADDR_NC_FIRST + 2 * i), base_val[i]);
            expect_csr($sformatf("nc limit csr %0d", i),
                       csr_addr_t'(ADDR_NC_FIRST + 2 * i + 1), limit_val[i]);
            check($sformatf("nc_base[%0d]", i), nc_base[i], base_val[i]);
            check($sformatf("nc_limit[%0d]", i), nc_limit[i], limit_val[i]);
        end
    endtask

    task automatic flush_test();
        csr_access(ADDR_FLUSH, 3'd1, 32'h1, 1'b1);
        // high in the cycle after the write only
        check("flush_cache_flag", {31'd0, flush_cache_flag}, 32'd1);
        step();
        check("flush_cache_flag", {31'd0, flush_cache_flag}, 32'd0);
        expect_csr("flush", ADDR_FLUSH, 32'h0);
    endtask

    task automatic exception_test();
        csr_data_t pc;
        csr_data_t second_pc;
        csr_access(ADDR_MSTATUS, 3'd2, 32'h8, 1'b1);
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1808);
        pc              = $urandom & 32'hFFFF_FFFC;
        current_pc      = pc;
        exception       = 1'b1;
        exception_cause = 31'd2;
        #1;
        check("trap", {31'd0, trap}, 32'd1);
        step();
        exception = 1'b0;
        check("csr_mepc", csr_mepc, pc);
        expect_csr("mepc", ADDR_MEPC, pc);
        expect_csr("mcause", ADDR_MCAUSE, 32'h2);
        // mpie holds the old mie, mie cleared
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1880);
        // second exception inside the handler is held off
        current_pc      = pc + 32'd4;
        exception       = 1'b1;
        exception_cause = 31'd5;
        #1;
        check("trap", {31'd0, trap}, 32'd0);
        step();
        exception = 1'b0;
        expect_csr("mepc", ADDR_MEPC, pc);
        expect_csr("mcause", ADDR_MCAUSE, 32'h2);
        m_ret = 1'b1;
        step();
        m_ret = 1'b0;
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1888);
        // traps again after the return
        second_pc       = $urandom & 32'hFFFF_FFFC;
        current_pc      = second_pc;
        exception       = 1'b1;
        exception_cause = 31'd5;
        #1;
        check("trap", {31'd0, trap}, 32'd1);
        step();
        exception = 1'b0;
        expect_csr("mepc", ADDR_MEPC, second_pc);
        expect_csr("mcause", ADDR_MCAUSE, 32'h5);
        m_ret = 1'b1;
        step();
        m_ret = 1'b0;
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1888);
    endtask

    task automatic interrupt_test();
        int cycles;
        // soft, timer and external enabled
        csr_access(ADDR_MIE, 3'd1, 32'h0000_0888, 1'b1);
        timer_itr = 1'b1;
        ext_itr   = 1'b1;
        wait_for_trap(4, cycles);
        check("trap latency", cycles, 32'd1);
        expect_csr("mip", ADDR_MIP, 32'h0000_0880);
        // external wins over timer
        expect_csr("mcause", ADDR_MCAUSE, 32'h8000_000B);
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1880);
        timer_itr = 1'b0;
        ext_itr   = 1'b0;
        m_ret     = 1'b1;
        step();
        m_ret = 1'b0;
        expect_csr("mstatus", ADDR_MSTATUS, 32'h0000_1888);
        expect_csr("mip", ADDR_MIP, 32'h0);
        // timer alone
        timer_itr = 1'b1;
        wait_for_trap(4, cycles);
        check("trap latency", cycles, 32'd1);
        expect_csr("mcause", ADDR_MCAUSE, 32'h8000_0007);
        timer_itr = 1'b0;
        m_ret     = 1'b1;
        step();
        m_ret = 1'b0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        void'($urandom(32'h81834e85));
        mismatches      = 0;
        failures        = 0;
        clk             = 1'b0;
        rst_n           = 1'b0;
        current_pc      = '0;
        exception       = 1'b0;
        exception_cause = '0;
        m_ret           = 1'b0;
        timer_itr       = 1'b0;
        soft_itr        = 1'b0;
        ext_itr         = 1'b0;
        bus_idle();
        // two reset edges, release at a drive point
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        reset_values_test();
        write_forms_test();
        windows_test();
        flush_test();
        exception_test();
        interrupt_test();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/csr_file_asserts.sv */
`default_nettype none

module csr_file_asserts (
    input logic clk,
    input logic rst_n,
    input logic trap,
    input logic flush_cache_flag,
    input logic trap_taken
);

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // trap and flush properties
    // --------------------------------------------------

    // flush request is a one-cycle pulse
    flush_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush_cache_flag |=> !flush_cache_flag)
        else $error("flush_cache_flag high on two consecutive cycles");

    // a taken trap marks the handler, no nested trap follows
    trap_sets_taken_a: assert property (@(posedge clk) disable iff (!rst_n)
        trap |=> (trap_taken && !trap))
        else $error("trap_taken not set, or trap raised again, after a trap");

    // quiet right after a reset edge
    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |=> (!trap && !flush_cache_flag))
        else $error("trap or flush_cache_flag high in the cycle after reset");

endmodule

// one checker per core register block
bind core_csrs csr_file_asserts u_asserts (
    .clk             (clk),
    .rst_n           (rst_n),
    .trap            (trap),
    .flush_cache_flag(flush_cache_flag),
    .trap_taken      (trap_taken)
);

`default_nettype wire

/* source/csr_file_top.sv */
`default_nettype none

module csr_file_top #(
    parameter int N_REGIONS = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_addr_t address,
    input  csr_pkg::csr_f3_t   f3,
    input  csr_pkg::csr_data_t write_data,
    input  logic               write_enable,
    input  logic               instruction_valid,
    input  csr_pkg::csr_data_t current_pc,
    input  logic               exception,
    input  csr_pkg::cause_t    exception_cause,
    input  logic               m_ret,
    input  logic               timer_itr,
    input  logic               soft_itr,
    input  logic               ext_itr,
    output csr_pkg::csr_data_t read_data,
    output logic               trap,
    output csr_pkg::csr_data_t csr_mtvec,
    output csr_pkg::csr_data_t csr_mepc,
    output logic               flush_cache_flag,
    output csr_pkg::csr_data_t nc_base  [N_REGIONS],
    output csr_pkg::csr_data_t nc_limit [N_REGIONS]
);

    import csr_pkg::*;

    localparam int SEL_W = CORE_SLOTS + 2 * N_REGIONS;

    typedef logic [SEL_W-1:0] sel_t;

    sel_t      sel;
    sel_t      wr_en;
    csr_data_t wb_value;
    csr_data_t mstatus;
    csr_data_t mie;
    csr_data_t mip;
    csr_data_t mcause;
    csr_data_t mscratch;
    csr_data_t flush;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------

    csr_access_decode #(
        .N_REGIONS(N_REGIONS)
    ) u_decode (
        .address          (address),
        .instruction_valid(instruction_valid),
        .write_enable     (write_enable),
        .sel              (sel),
        .wr_en            (wr_en)
    );

    // --------------------------------------------------
    // machine registers and traps
    // --------------------------------------------------

    core_csrs u_core (
        .clk             (clk),
        .rst_n           (rst_n),
        .sel_wr          (wr_en[CORE_SLOTS-1:0]),
        .wb_value        (wb_value),
        .current_pc      (current_pc),
        .exception       (exception),
        .exception_cause (exception_cause),
        .m_ret           (m_ret),
        .timer_itr       (timer_itr),
        .soft_itr        (soft_itr),
        .ext_itr         (ext_itr),
        .trap            (trap),
        .flush_cache_flag(flush_cache_flag),
        .mstatus         (mstatus),
        .mie             (mie),
        .mip             (mip),
        .mtvec           (csr_mtvec),
        .mepc            (csr_mepc),
        .mcause          (mcause),
        .mscratch        (mscratch),
        .flush           (flush)
    );

    // --------------------------------------------------
    // non-cachable windows
    // --------------------------------------------------

    // region 0 data side, region 1 instruction side
    for (genvar r = 0; r < N_REGIONS; r++) begin : g_region
        nc_region_csr u_region (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_base (wr_en[CORE_SLOTS + 2 * r]),
            .wr_limit(wr_en[CORE_SLOTS + 2 * r + 1]),
            .wb_value(wb_value),
            .base    (nc_base[r]),
            .limit   (nc_limit[r])
        );
    end

    // read path and write-back value
    csr_read_mux #(
        .N_REGIONS(N_REGIONS)
    ) u_read_mux (
        .sel         (sel),
        .f3          (f3),
        .write_data  (write_data),
        .mstatus     (mstatus),
        .mie         (mie),
        .mip         (mip),
        .mtvec       (csr_mtvec),
        .mepc        (csr_mepc),
        .mcause      (mcause),
        .mscratch    (mscratch),
        .flush       (flush),
        .region_base (nc_base),
        .region_limit(nc_limit),
        .read_data   (read_data),
        .wb_value    (wb_value)
    );

endmodule

`default_nettype wire

/* source/csr_read_mux.sv */
`default_nettype none

module csr_read_mux #(
    parameter int N_REGIONS = 2
) (
    input  logic [csr_pkg::CORE_SLOTS+2*N_REGIONS-1:0]  sel,
    input  csr_pkg::csr_f3_t                            f3,
    input  csr_pkg::csr_data_t                          write_data,
    input  csr_pkg::csr_data_t                          mstatus,
    input  csr_pkg::csr_data_t                          mie,
    input  csr_pkg::csr_data_t                          mip,
    input  csr_pkg::csr_data_t                          mtvec,
    input  csr_pkg::csr_data_t                          mepc,
    input  csr_pkg::csr_data_t                          mcause,
    input  csr_pkg::csr_data_t                          mscratch,
    input  csr_pkg::csr_data_t                          flush,
    input  csr_pkg::csr_data_t                          region_base  [N_REGIONS],
    input  csr_pkg::csr_data_t                          region_limit [N_REGIONS],
    output csr_pkg::csr_data_t                          read_data,
    output csr_pkg::csr_data_t                          wb_value
);

    import csr_pkg::*;

    // --------------------------------------------------
    // read select, and-or over the one-hot
    // --------------------------------------------------

    always_comb begin
        // unmapped reads 0
        read_data = '0;
        if (sel[SEL_MSTATUS])  read_data |= mstatus;
        // misa is constant
        if (sel[SEL_MISA])     read_data |= MISA_VALUE;
        if (sel[SEL_MIE])      read_data |= mie;
        if (sel[SEL_MIP])      read_data |= mip;
        if (sel[SEL_MTVEC])    read_data |= mtvec;
        if (sel[SEL_MEPC])     read_data |= mepc;
        if (sel[SEL_MCAUSE])   read_data |= mcause;
        if (sel[SEL_MSCRATCH]) read_data |= mscratch;
        if (sel[SEL_FLUSH])    read_data |= flush;
        for (int i = 0; i < N_REGIONS; i++) begin
            if (sel[CORE_SLOTS + 2 * i])     read_data |= region_base[i];
            if (sel[CORE_SLOTS + 2 * i + 1]) read_data |= region_limit[i];
        end
    end

    // --------------------------------------------------
    // write-back value
    // --------------------------------------------------

    // register and immediate forms share the low two bits
    always_comb begin
        case (f3)
            3'b001, 3'b101: wb_value = write_data;
            3'b010, 3'b110: wb_value = read_data | write_data;
            3'b011, 3'b111: wb_value = read_data & ~write_data;
            default:        wb_value = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/nc_region_csr.sv */
`default_nettype none

module nc_region_csr (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_base,
    input  logic               wr_limit,
    input  csr_pkg::csr_data_t wb_value,
    output csr_pkg::csr_data_t base,
    output csr_pkg::csr_data_t limit
);

    import csr_pkg::*;

    // --------------------------------------------------
    // one non-cachable window
    // --------------------------------------------------

    // whole space non-cachable out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            base  <= '0;
            limit <= NC_LIMIT_RESET;
        end else begin
            // separate strobes, base and limit load apart
            if (wr_base) begin
                base <= wb_value;
            end
            if (wr_limit) begin
                limit <= wb_value;
            end
        end
    end

endmodule

`default_nettype wire

/* source/core_csrs.sv */
`default_nettype none

module core_csrs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [csr_pkg::CORE_SLOTS-1:0]  sel_wr,
    input  csr_pkg::csr_data_t              wb_value,
    input  csr_pkg::csr_data_t              current_pc,
    input  logic                            exception,
    input  csr_pkg::cause_t                 exception_cause,
    input  logic                            m_ret,
    input  logic                            timer_itr,
    input  logic                            soft_itr,
    input  logic                            ext_itr,
    output logic                            trap,
    output logic                            flush_cache_flag,
    output csr_pkg::csr_data_t              mstatus,
    output csr_pkg::csr_data_t              mie,
    output csr_pkg::csr_data_t              mip,
    output csr_pkg::csr_data_t              mtvec,
    output csr_pkg::csr_data_t              mepc,
    output csr_pkg::csr_data_t              mcause,
    output csr_pkg::csr_data_t              mscratch,
    output csr_pkg::csr_data_t              flush
);

    import csr_pkg::*;

    // set while a handler runs, until mret
    logic      trap_taken;
    csr_data_t irq_pending;
    logic      irq_take;
    cause_t    irq_cause;

    // --------------------------------------------------
    // trap request
    // --------------------------------------------------

    assign irq_pending = mie & mip;
    // interrupts need the global enable
    assign irq_take    = (|irq_pending) & mstatus[MIE_BIT];
    // no nesting, a pending trap waits for mret
    assign trap        = (irq_take | exception) & ~trap_taken;

    // fixed interrupt order: ext, timer, soft
    always_comb begin
        irq_cause = '0;
        if (irq_pending[IRQ_EXT]) begin
            irq_cause = cause_t'(IRQ_EXT);
        end else if (irq_pending[IRQ_TIMER]) begin
            irq_cause = cause_t'(IRQ_TIMER);
        end else if (irq_pending[IRQ_SOFT]) begin
            irq_cause = cause_t'(IRQ_SOFT);
        end
    end

    // cache flush pulse, bit 0 only
    assign flush_cache_flag = flush[0];

    // --------------------------------------------------
    // register update
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus    <= MSTATUS_RESET;
            mie        <= '0;
            mip        <= '0;
            mtvec      <= '0;
            mepc       <= '0;
            mcause     <= '0;
            mscratch   <= '0;
            flush      <= '0;
            trap_taken <= 1'b0;
        end else begin
            // interrupt lines sampled, one cycle late
            mip            <= '0;
            mip[IRQ_SOFT]  <= soft_itr;
            mip[IRQ_TIMER] <= timer_itr;
            mip[IRQ_EXT]   <= ext_itr;

            // trap beats mret beats software
            if (trap) begin
                mstatus[MPIE_BIT] <= mstatus[MIE_BIT];
                mstatus[MIE_BIT]  <= 1'b0;
            end else if (m_ret) begin
                mstatus[MIE_BIT] <= mstatus[MPIE_BIT];
            end else if (sel_wr[SEL_MSTATUS]) begin
                mstatus <= wb_value;
            end

            if (sel_wr[SEL_MIE]) begin
                mie <= wb_value;
            end
            if (sel_wr[SEL_MTVEC]) begin
                mtvec <= wb_value;
            end
            if (sel_wr[SEL_MSCRATCH]) begin
                mscratch <= wb_value;
            end

            // return address of the trapped instruction
            if (trap) begin
                mepc <= current_pc;
            end else if (sel_wr[SEL_MEPC]) begin
                mepc <= wb_value;
            end

            // bit 31 flags an interrupt
            if (trap) begin
                mcause <= {irq_take, irq_take ? irq_cause : exception_cause};
            end else if (sel_wr[SEL_MCAUSE]) begin
                mcause <= wb_value;
            end

            // self clearing, flag lasts one cycle
            if (flush[0]) begin
                flush <= '0;
            end else if (sel_wr[SEL_FLUSH]) begin
                flush <= wb_value;
            end

            if (trap) begin
                trap_taken <= 1'b1;
            end else if (m_ret) begin
                trap_taken <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/csr_access_decode.sv */
`default_nettype none

module csr_access_decode #(
    parameter int N_REGIONS = 2
) (
    input  csr_pkg::csr_addr_t                          address,
    input  logic                                        instruction_valid,
    input  logic                                        write_enable,
    output logic [csr_pkg::CORE_SLOTS+2*N_REGIONS-1:0]  sel,
    output logic [csr_pkg::CORE_SLOTS+2*N_REGIONS-1:0]  wr_en
);

    import csr_pkg::*;

    localparam int SEL_W = CORE_SLOTS + 2 * N_REGIONS;

    // --------------------------------------------------
    // address to one-hot select
    // --------------------------------------------------

    always_comb begin
        sel = '0;
        // fixed machine registers
        case (address)
            ADDR_MSTATUS:  sel[SEL_MSTATUS]  = 1'b1;
            ADDR_MISA:     sel[SEL_MISA]     = 1'b1;
            ADDR_MIE:      sel[SEL_MIE]      = 1'b1;
            ADDR_MIP:      sel[SEL_MIP]      = 1'b1;
            ADDR_MTVEC:    sel[SEL_MTVEC]    = 1'b1;
            ADDR_MEPC:     sel[SEL_MEPC]     = 1'b1;
            ADDR_MCAUSE:   sel[SEL_MCAUSE]   = 1'b1;
            ADDR_MSCRATCH: sel[SEL_MSCRATCH] = 1'b1;
            ADDR_FLUSH:    sel[SEL_FLUSH]    = 1'b1;
            default:       ;
        endcase
        // window pairs, base then limit
        for (int i = 0; i < N_REGIONS; i++) begin
            if (address == csr_addr_t'(ADDR_NC_FIRST + 2 * i)) begin
                sel[CORE_SLOTS + 2 * i] = 1'b1;
            end
            if (address == csr_addr_t'(ADDR_NC_FIRST + 2 * i + 1)) begin
                sel[CORE_SLOTS + 2 * i + 1] = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // write strobes
    // --------------------------------------------------

    // only a valid instruction with a write request commits
    assign wr_en = sel & {SEL_W{instruction_valid & write_enable}};

endmodule

`default_nettype wire

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // --------------------------------------------------
    // data widths
    // --------------------------------------------------

    typedef logic [31:0] csr_data_t;
    typedef logic [11:0] csr_addr_t;
    // funct3 of the csr instruction, picks write form
    typedef logic [2:0]  csr_f3_t;
    // trap cause code, interrupt flag kept apart
    typedef logic [30:0] cause_t;

    // --------------------------------------------------
    // csr address map
    // --------------------------------------------------

    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;
    // custom cache control space
    localparam csr_addr_t ADDR_FLUSH    = 12'h7C0;
    // window i base at first + 2i, limit right after
    localparam csr_addr_t ADDR_NC_FIRST = 12'h7C1;

    // one-hot select positions, window slots follow the core ones
    localparam int SEL_MSTATUS  = 0;
    localparam int SEL_MISA     = 1;
    localparam int SEL_MIE      = 2;
    localparam int SEL_MIP      = 3;
    localparam int SEL_MTVEC    = 4;
    localparam int SEL_MEPC     = 5;
    localparam int SEL_MCAUSE   = 6;
    localparam int SEL_MSCRATCH = 7;
    localparam int SEL_FLUSH    = 8;
    localparam int CORE_SLOTS   = 9;

    // mstatus fields
    localparam int MIE_BIT   = 3;
    localparam int MPIE_BIT  = 7;
    // mip / mie positions, equal to their cause codes
    localparam int IRQ_SOFT  = 3;
    localparam int IRQ_TIMER = 7;
    localparam int IRQ_EXT   = 11;

    // reset values
    localparam csr_data_t MSTATUS_RESET  = 32'h0000_1800;
    localparam csr_data_t MISA_VALUE     = 32'h4014_0100;
    localparam csr_data_t NC_LIMIT_RESET = 32'hFFFF_FFFF;

endpackage

`default_nettype wire
